/* Makefile */
# Verilator build and run for the icache testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no pass line in log"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
design/icache_pkg.sv
design/ic_tag_array.sv
design/ic_data_array.sv
design/ic_replace_ctrl.sv
design/ic_miss_ctrl.sv
design/ic_lookup_pipe.sv
design/ic_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* design/ic_data_array.sv */
// icache data array: synchronous line RAM with registered read and full-line write
`default_nettype none

module ic_data_array (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_wr,
  input  logic [icache_pkg::INDEX_W-1:0] i_addr,
  input  logic [icache_pkg::LINE_W-1:0]  i_data,
  output logic [icache_pkg::LINE_W-1:0]  o_data
);

  logic [icache_pkg::LINE_W-1:0] r_line_mem [icache_pkg::SETS];

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_line_mem[i_addr] <= i_data;   // whole line
    end
  end

  // read every cycle, old data on a same-address write
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_data <= '0;
    end else begin
      o_data <= r_line_mem[i_addr];
    end
  end

endmodule

`default_nettype wire

/* design/ic_lookup_pipe.sv */
// icache lookup pipeline: s0 request, s1 tag compare, s2 way select and response
`default_nettype none

module ic_lookup_pipe (
  input  logic                                                i_clk,
  input  logic                                                i_reset_n,
  input  icache_pkg::ic_req_t                                 i_s0_req,
  input  logic                                                i_s1_kill,
  input  logic                                                i_flush,
  input  logic                                                i_fence_i,
  input  logic                                                i_busy,
  input  logic                                                i_fill,
  input  logic [icache_pkg::VADDR_W-1:0]                      i_fill_vaddr,
  output logic                                                o_tag_rd,
  output logic [icache_pkg::INDEX_W-1:0]                      o_tag_addr,
  output logic [icache_pkg::INDEX_W-1:0]                      o_data_addr,
  input  logic [icache_pkg::WAYS-1:0][icache_pkg::TAG_W-1:0]  i_way_tag,
  input  logic [icache_pkg::WAYS-1:0]                         i_way_tag_valid,
  input  logic [icache_pkg::WAYS-1:0][icache_pkg::LINE_W-1:0] i_way_data,
  output logic                                                o_miss_start,
  output logic [icache_pkg::VADDR_W-1:0]                      o_miss_vaddr,
  output icache_pkg::ic_resp_t                                o_s2_resp,
  output logic                                                o_s2_miss,
  output logic [icache_pkg::VADDR_W-1:0]                      o_s2_miss_vaddr,
  output logic                                                o_adv,
  output logic [icache_pkg::INDEX_W-1:0]                      o_adv_set
);

  // s1
  logic                           r_s1_valid;
  logic [icache_pkg::VADDR_W-1:0] r_s1_vaddr;
  logic [icache_pkg::WAYS-1:0]    w_s1_tag_hit;
  logic                           w_s1_hit;

  // s2
  logic                           r_s2_valid;
  logic [icache_pkg::WAYS-1:0]    r_s2_tag_hit;   // one-hot
  logic [icache_pkg::VADDR_W-1:0] r_s2_vaddr;
  logic [icache_pkg::LINE_W-1:0]  w_s2_data;
  logic                           w_s2_resp_valid;

  // ========================================
  // s0: array addressing
  // ========================================
  assign o_tag_rd    = i_s0_req.valid & ~i_busy;   // accepted request
  assign o_tag_addr  = i_fill ? i_fill_vaddr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W] :
                                i_s0_req.vaddr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign o_data_addr = i_fill ? i_fill_vaddr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W] :
                                r_s1_vaddr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

  // ========================================
  // s1: tag compare and miss decision
  // ========================================
  always_comb begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      w_s1_tag_hit[w] = i_way_tag_valid[w] &
        (i_way_tag[w] == r_s1_vaddr[icache_pkg::VADDR_W-1 -: icache_pkg::TAG_W]);
    end
  end

  assign w_s1_hit = |w_s1_tag_hit;

  assign o_miss_start = r_s1_valid & ~w_s1_hit & ~i_busy & ~i_s1_kill &
                        ~i_flush & ~i_fence_i;
  assign o_miss_vaddr = r_s1_vaddr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid   <= 1'b0;
      r_s2_valid   <= 1'b0;
      r_s2_tag_hit <= '0;
      o_s2_miss    <= 1'b0;
    end else begin
      r_s1_valid   <= o_tag_rd;                // flush does not drop the new request
      r_s2_valid   <= r_s1_valid & ~i_flush;
      r_s2_tag_hit <= r_s1_valid ? w_s1_tag_hit : '0;
      // missed while idle, or arrived while a refill is running
      o_s2_miss    <= r_s1_valid & ((~i_busy & ~i_flush & ~w_s1_hit) | i_busy);
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr      <= i_s0_req.vaddr;
    r_s2_vaddr      <= r_s1_vaddr;
    o_s2_miss_vaddr <= r_s1_vaddr;
  end

  // ========================================
  // s2: way select and response
  // ========================================
  always_comb begin
    w_s2_data = '0;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (r_s2_tag_hit[w]) w_s2_data = w_s2_data | i_way_data[w];
    end
  end

  assign w_s2_resp_valid = r_s2_valid & (|r_s2_tag_hit) & ~i_busy & ~i_flush;

  assign o_s2_resp.valid = w_s2_resp_valid;
  assign o_s2_resp.vaddr = r_s2_vaddr;
  assign o_s2_resp.data  = w_s2_data;
  // clear bytes below the fetch offset
  assign o_s2_resp.be    = {icache_pkg::LINE_BYTES{1'b1}} <<
                           r_s2_vaddr[icache_pkg::OFFSET_W-1:0];

  assign o_adv     = w_s2_resp_valid;
  assign o_adv_set = r_s2_vaddr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

endmodule

`default_nettype wire

/* design/ic_miss_ctrl.sv */
// icache miss controller: single outstanding line refill over the memory port
`default_nettype none

module ic_miss_ctrl (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_start,
  input  logic [icache_pkg::VADDR_W-1:0] i_miss_vaddr,
  input  logic                           i_fence_i,
  output logic                           o_busy,
  output icache_pkg::l2_req_t            o_l2_req,
  input  logic                           i_l2_req_ready,
  input  icache_pkg::l2_resp_t           i_l2_resp,
  output logic                           o_fill,
  output logic [icache_pkg::VADDR_W-1:0] o_fill_vaddr,
  output logic [icache_pkg::LINE_W-1:0]  o_fill_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RESP,
    ST_INVAL
  } state_t;

  state_t                            r_state;
  logic [icache_pkg::VADDR_W-1:0]    r_vaddr;
  logic [icache_pkg::L2_TAG_W-1:0]   r_req_tag;
  logic                              r_fence_pend;   // fence seen before transfer
  logic                              w_resp_fire;

  assign w_resp_fire = i_l2_resp.valid & (i_l2_resp.tag == r_req_tag) &
                       ((r_state == ST_RESP) | (r_state == ST_INVAL));

  // ========================================
  // refill FSM
  // ========================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= ST_IDLE;
      r_req_tag    <= '0;
      r_fence_pend <= 1'b0;
    end else begin
      case (r_state)
        ST_IDLE: begin
          r_fence_pend <= 1'b0;
          if (i_start) r_state <= ST_REQ;
        end
        ST_REQ: begin
          if (i_fence_i) r_fence_pend <= 1'b1;
          if (i_l2_req_ready) begin
            r_state <= (r_fence_pend | i_fence_i) ? ST_INVAL : ST_RESP;
          end
        end
        ST_RESP: begin
          if (w_resp_fire) begin
            r_state   <= ST_IDLE;
            r_req_tag <= r_req_tag + 1'b1;
          end else if (i_fence_i) begin
            r_state <= ST_INVAL;
          end
        end
        default: begin   // drain the response, install nothing
          if (w_resp_fire) begin
            r_state   <= ST_IDLE;
            r_req_tag <= r_req_tag + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == ST_IDLE) && i_start) begin
      r_vaddr <= i_miss_vaddr;
    end
  end

  assign o_busy = (r_state != ST_IDLE);

  // request held steady until transfer
  assign o_l2_req.valid = (r_state == ST_REQ);
  assign o_l2_req.cmd   = icache_pkg::L2_CMD_RD;
  assign o_l2_req.addr  = {r_vaddr[icache_pkg::VADDR_W-1:icache_pkg::OFFSET_W],
                           {icache_pkg::OFFSET_W{1'b0}}};
  assign o_l2_req.tag   = r_req_tag;

  // a fence on the fire edge also drops the fill
  assign o_fill       = w_resp_fire & (r_state == ST_RESP) & ~i_fence_i;
  assign o_fill_vaddr = r_vaddr;
  assign o_fill_data  = i_l2_resp.data;

endmodule

`default_nettype wire

/* design/ic_replace_ctrl.sv */
// icache replacement: per-set round-robin victim pointers
`default_nettype none

module ic_replace_ctrl (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic                             i_adv,
  input  logic [icache_pkg::INDEX_W-1:0]   i_adv_set,
  input  logic [icache_pkg::INDEX_W-1:0]   i_fill_set,
  output logic [icache_pkg::WAY_IDX_W-1:0] o_fill_way
);

  logic [icache_pkg::WAY_IDX_W-1:0] r_ptr [icache_pkg::SETS];
  logic [icache_pkg::WAY_IDX_W-1:0] w_cur_ptr;
  logic [icache_pkg::WAY_IDX_W-1:0] w_next_ptr;

  assign w_cur_ptr = r_ptr[i_adv_set];

  // wrap at the last way
  assign w_next_ptr = (w_cur_ptr == icache_pkg::WAY_IDX_W'(icache_pkg::WAYS - 1)) ?
                      '0 : w_cur_ptr + 1'b1;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < icache_pkg::SETS; i++) begin
        r_ptr[i] <= '0;
      end
    end else if (i_adv) begin
      r_ptr[i_adv_set] <= w_next_ptr;
    end
  end

  assign o_fill_way = r_ptr[i_fill_set];   // victim for the refill

endmodule

`default_nettype wire

/* design/ic_tag_array.sv */
// icache tag array: one tag and valid bit per set, registered read, bulk clear
`default_nettype none

module ic_tag_array (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_clear,
  input  logic                           i_wr,
  input  logic                           i_rd,
  input  logic [icache_pkg::INDEX_W-1:0] i_addr,
  input  logic [icache_pkg::TAG_W-1:0]   i_tag,
  output logic [icache_pkg::TAG_W-1:0]   o_tag,
  output logic                           o_tag_valid
);

  logic [icache_pkg::TAG_W-1:0] r_tag_mem [icache_pkg::SETS];
  logic [icache_pkg::SETS-1:0]  r_valid;

  // tag storage and read port
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tag_mem[i_addr] <= i_tag;
    end
    if (i_rd) begin
      o_tag <= r_tag_mem[i_addr];
    end
  end

  // valid bits
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      if (i_clear) begin
        r_valid <= '0;
      end else if (i_wr) begin
        r_valid[i_addr] <= 1'b1;
      end
    end
  end

  // a fence on the read edge already reads as invalid
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_tag_valid <= 1'b0;
    end else if (i_clear) begin
      o_tag_valid <= 1'b0;
    end else if (i_rd) begin
      o_tag_valid <= r_valid[i_addr];
    end
  end

endmodule

`default_nettype wire

/* design/ic_top.sv */
// icache top: two-way instruction cache with lookup pipeline and line refill
`default_nettype none

module ic_top (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  icache_pkg::ic_req_t            i_s0_req,
  output logic                           o_s0_ready,
  input  logic                           i_s1_kill,
  input  logic                           i_flush,
  input  logic                           i_fence_i,
  output icache_pkg::ic_resp_t           o_s2_resp,
  output logic                           o_s2_miss,
  output logic [icache_pkg::VADDR_W-1:0] o_s2_miss_vaddr,
  output icache_pkg::l2_req_t            o_l2_req,
  input  logic                           i_l2_req_ready,
  input  icache_pkg::l2_resp_t           i_l2_resp
);

  logic                                                w_busy;
  logic                                                w_fill;
  logic [icache_pkg::VADDR_W-1:0]                      w_fill_vaddr;
  logic [icache_pkg::LINE_W-1:0]                       w_fill_data;
  logic [icache_pkg::WAY_IDX_W-1:0]                    w_fill_way;
  logic                                                w_tag_rd;
  logic [icache_pkg::INDEX_W-1:0]                      w_tag_addr;
  logic [icache_pkg::INDEX_W-1:0]                      w_data_addr;
  logic [icache_pkg::WAYS-1:0][icache_pkg::TAG_W-1:0]  w_way_tag;
  logic [icache_pkg::WAYS-1:0]                         w_way_tag_valid;
  logic [icache_pkg::WAYS-1:0][icache_pkg::LINE_W-1:0] w_way_data;
  logic [icache_pkg::WAYS-1:0]                         w_way_wr;
  logic                                                w_miss_start;
  logic [icache_pkg::VADDR_W-1:0]                      w_miss_vaddr;
  logic                                                w_adv;
  logic [icache_pkg::INDEX_W-1:0]                      w_adv_set;

  assign o_s0_ready = ~w_busy;

  ic_lookup_pipe u_pipe (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_s0_req        (i_s0_req),
    .i_s1_kill       (i_s1_kill),
    .i_flush         (i_flush),
    .i_fence_i       (i_fence_i),
    .i_busy          (w_busy),
    .i_fill          (w_fill),
    .i_fill_vaddr    (w_fill_vaddr),
    .o_tag_rd        (w_tag_rd),
    .o_tag_addr      (w_tag_addr),
    .o_data_addr     (w_data_addr),
    .i_way_tag       (w_way_tag),
    .i_way_tag_valid (w_way_tag_valid),
    .i_way_data      (w_way_data),
    .o_miss_start    (w_miss_start),
    .o_miss_vaddr    (w_miss_vaddr),
    .o_s2_resp       (o_s2_resp),
    .o_s2_miss       (o_s2_miss),
    .o_s2_miss_vaddr (o_s2_miss_vaddr),
    .o_adv           (w_adv),
    .o_adv_set       (w_adv_set)
  );

  ic_miss_ctrl u_miss (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_start        (w_miss_start),
    .i_miss_vaddr   (w_miss_vaddr),
    .i_fence_i      (i_fence_i),
    .o_busy         (w_busy),
    .o_l2_req       (o_l2_req),
    .i_l2_req_ready (i_l2_req_ready),
    .i_l2_resp      (i_l2_resp),
    .o_fill         (w_fill),
    .o_fill_vaddr   (w_fill_vaddr),
    .o_fill_data    (w_fill_data)
  );

  ic_replace_ctrl u_replace (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_adv      (w_adv),
    .i_adv_set  (w_adv_set),
    .i_fill_set (w_fill_vaddr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W]),
    .o_fill_way (w_fill_way)
  );

  // ========================================
  // per-way arrays
  // ========================================
  for (genvar way = 0; way < icache_pkg::WAYS; way++) begin : g_way
    assign w_way_wr[way] = w_fill &
                           (w_fill_way == icache_pkg::WAY_IDX_W'(way));   // victim only

    ic_tag_array u_tag (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_clear     (i_fence_i),
      .i_wr        (w_way_wr[way]),
      .i_rd        (w_tag_rd),
      .i_addr      (w_tag_addr),
      .i_tag       (w_fill_vaddr[icache_pkg::VADDR_W-1 -: icache_pkg::TAG_W]),
      .o_tag       (w_way_tag[way]),
      .o_tag_valid (w_way_tag_valid[way])
    );

    ic_data_array u_data (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_way_wr[way]),
      .i_addr    (w_data_addr),
      .i_data    (w_fill_data),
      .o_data    (w_way_data[way])
    );
  end

endmodule

`default_nettype wire

/* design/icache_pkg.sv */
// icache package: cache geometry and the fetch and memory port structs
`default_nettype none

package icache_pkg;

  // ========================================
  // geometry
  // ========================================
  localparam int VADDR_W    = 32;
  localparam int LINE_BYTES = 16;
  localparam int LINE_W     = LINE_BYTES * 8;   // 128 bits
  localparam int OFFSET_W   = $clog2(LINE_BYTES);
  localparam int SETS       = 16;
  localparam int INDEX_W    = $clog2(SETS);
  localparam int WAYS       = 2;
  localparam int WAY_IDX_W  = $clog2(WAYS);
  localparam int TAG_W      = VADDR_W - INDEX_W - OFFSET_W;

  // memory port
  localparam int L2_TAG_W = 4;
  localparam logic [1:0] L2_CMD_RD = 2'd0;   // line read

  // ========================================
  // fetch side
  // ========================================
  typedef struct packed {
    logic               valid;
    logic [VADDR_W-1:0] vaddr;
  } ic_req_t;

  typedef struct packed {
    logic                  valid;
    logic [VADDR_W-1:0]    vaddr;
    logic [LINE_W-1:0]     data;
    logic [LINE_BYTES-1:0] be;    // bytes at or above the fetch offset
  } ic_resp_t;

  // ========================================
  // memory side
  // ========================================
  typedef struct packed {
    logic                valid;
    logic [1:0]          cmd;
    logic [VADDR_W-1:0]  addr;   // line aligned
    logic [L2_TAG_W-1:0] tag;
  } l2_req_t;

  typedef struct packed {
    logic                valid;
    logic [L2_TAG_W-1:0] tag;
    logic [LINE_W-1:0]   data;
  } l2_resp_t;

endpackage

`default_nettype wire

/* testbench/tb_checker.sv */
// icache checker: cache and memory model, compares DUT outputs every cycle
`default_nettype none

module tb_checker (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  icache_pkg::ic_req_t  i_s0_req,
  input  logic                 i_s0_ready,
  input  logic                 i_s1_kill,
  input  logic                 i_flush,
  input  logic                 i_fence_i,
  input  icache_pkg::ic_resp_t i_s2_resp,
  input  logic                 i_s2_miss,
  input  logic [31:0]          i_s2_miss_vaddr,
  input  icache_pkg::l2_req_t  i_l2_req,
  input  logic                 i_l2_req_ready,
  input  icache_pkg::l2_resp_t i_l2_resp,
  output int                   o_errors,
  output int                   o_checks,
  output int                   o_hits,
  output int                   o_misses,
  output int                   o_fills
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {M_IDLE, M_REQ, M_RESP, M_INVAL} mstate_t;

  logic         m_valid [icache_pkg::SETS][icache_pkg::WAYS];
  logic [23:0]  m_tag   [icache_pkg::SETS][icache_pkg::WAYS];
  logic         m_ptr   [icache_pkg::SETS];
  logic [127:0] m_line  [64];   // backing memory copy
  mstate_t      m_state;
  logic         m_fence_pend;
  logic [3:0]   m_req_tag;
  logic [31:0]  m_vaddr;
  logic         s1_valid, s1_hit, s2_valid, s2_hit, s2_miss;
  logic [31:0]  s1_vaddr, s2_vaddr;
  int           seed;

  initial begin
    seed = 32'hbd56_9d1f;
    for (int i = 0; i < 64; i++) begin
      m_line[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    o_errors = 0;
    o_checks = 0;
    o_hits   = 0;
    o_misses = 0;
    o_fills  = 0;
  end

  task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
    o_checks++;
    if (exp !== act) begin
      o_errors++;
      $display("MISMATCH %s expected=%0h actual=%0h", name, exp, act);
    end
  endtask

  task automatic reset_model();
    for (int s = 0; s < icache_pkg::SETS; s++) begin
      m_ptr[s] = 1'b0;
      for (int w = 0; w < icache_pkg::WAYS; w++) m_valid[s][w] = 1'b0;
    end
    m_state      = M_IDLE;
    m_fence_pend = 1'b0;
    m_req_tag    = 4'd0;
    s1_valid     = 1'b0;
    s1_hit       = 1'b0;
    s2_valid     = 1'b0;
    s2_hit       = 1'b0;
    s2_miss      = 1'b0;
  endtask

  // ========================================
  // expected outputs for this cycle
  // ========================================
  task automatic compare_outputs();
    logic        busy;
    logic        exp_resp;
    logic [15:0] exp_be;
    busy = (m_state != M_IDLE);
    check("s0_ready", 128'(!busy), 128'(i_s0_ready));
    check("l2_req_valid", 128'(m_state == M_REQ), 128'(i_l2_req.valid));
    if (m_state == M_REQ) begin
      check("l2_req_addr", 128'({m_vaddr[31:4], 4'h0}), 128'(i_l2_req.addr));
      check("l2_req_tag", 128'(m_req_tag), 128'(i_l2_req.tag));
      check("l2_req_cmd", 128'(icache_pkg::L2_CMD_RD), 128'(i_l2_req.cmd));
    end
    exp_resp = s2_valid & s2_hit & !busy & !i_flush;
    check("resp_valid", 128'(exp_resp), 128'(i_s2_resp.valid));
    if (exp_resp) begin
      for (int b = 0; b < 16; b++) exp_be[b] = (b >= int'(s2_vaddr[3:0]));
      check("resp_vaddr", 128'(s2_vaddr), 128'(i_s2_resp.vaddr));
      check("resp_data", m_line[s2_vaddr[9:4]], i_s2_resp.data);
      check("resp_be", 128'(exp_be), 128'(i_s2_resp.be));
      o_hits++;
    end
    check("s2_miss", 128'(s2_miss), 128'(i_s2_miss));
    if (s2_miss) begin
      check("s2_miss_vaddr", 128'(s2_vaddr), 128'(i_s2_miss_vaddr));
      o_misses++;
    end
  endtask

  // ========================================
  // state update at the coming edge
  // ========================================
  task automatic advance_model();
    logic       busy, accept, fire, fill, start, resp_ok, new_hit, fway;
    logic [3:0] rset, fset;
    busy    = (m_state != M_IDLE);
    accept  = i_s0_req.valid & !busy;
    fire    = i_l2_resp.valid & (i_l2_resp.tag == m_req_tag) &
              ((m_state == M_RESP) | (m_state == M_INVAL));
    fill    = fire & (m_state == M_RESP) & !i_fence_i;
    start   = s1_valid & !s1_hit & !busy & !i_s1_kill & !i_flush & !i_fence_i;
    resp_ok = s2_valid & s2_hit & !busy & !i_flush;
    rset    = i_s0_req.vaddr[7:4];
    new_hit = 1'b0;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (m_valid[rset][w] && m_tag[rset][w] == i_s0_req.vaddr[31:8]) new_hit = 1'b1;
    end
    if (i_fence_i) new_hit = 1'b0;   // cleared on the read edge
    fset = m_vaddr[7:4];
    fway = m_ptr[fset];
    if (i_fence_i) begin
      for (int s = 0; s < icache_pkg::SETS; s++) begin
        for (int w = 0; w < icache_pkg::WAYS; w++) m_valid[s][w] = 1'b0;
      end
    end else if (fill) begin
      m_valid[fset][fway] = 1'b1;
      m_tag[fset][fway]   = m_vaddr[31:8];
      o_fills++;
    end
    if (resp_ok) m_ptr[s2_vaddr[7:4]] = ~m_ptr[s2_vaddr[7:4]];
    case (m_state)
      M_IDLE: begin
        m_fence_pend = 1'b0;
        if (start) begin
          m_state = M_REQ;
          m_vaddr = s1_vaddr;
        end
      end
      M_REQ: begin
        if (i_l2_req_ready) m_state = (m_fence_pend | i_fence_i) ? M_INVAL : M_RESP;
        if (i_fence_i) m_fence_pend = 1'b1;
      end
      M_RESP: begin
        if (fire) begin
          m_state   = M_IDLE;
          m_req_tag = m_req_tag + 4'd1;
        end else if (i_fence_i) begin
          m_state = M_INVAL;
        end
      end
      default: begin
        if (fire) begin
          m_state   = M_IDLE;
          m_req_tag = m_req_tag + 4'd1;
        end
      end
    endcase
    s2_miss  = s1_valid & ((!busy & !i_flush & !s1_hit) | busy);
    s2_valid = s1_valid & !i_flush;
    s2_hit   = s1_valid & s1_hit;
    s2_vaddr = s1_vaddr;
    s1_valid = accept;
    s1_hit   = new_hit;
    s1_vaddr = i_s0_req.vaddr;
  endtask

  // sample mid-cycle, everything settled
  always @(negedge i_clk) begin
    if (!i_reset_n) begin
      reset_model();
    end else begin
      compare_outputs();
      advance_model();
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// testbench clock and reset: 20 ns clock, reset held low for two cycles
`default_nettype none

module tb_clock (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (2) @(posedge o_clk);
    o_reset_n <= 1'b1;   // released on an edge
  end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
// icache testbench top with random fetch stimulus and a line memory of variable latency
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  logic                 clk, reset_n;
  icache_pkg::ic_req_t  s0_req;
  logic                 s0_ready, s1_kill, flush, fence_i;
  icache_pkg::ic_resp_t s2_resp;
  logic                 s2_miss;
  logic [31:0]          s2_miss_vaddr;
  icache_pkg::l2_req_t  l2_req;
  logic                 l2_req_ready;
  icache_pkg::l2_resp_t l2_resp;
  int                   errors, checks, hits, misses, fills;

  int           seed;
  logic [127:0] backing [64];
  logic         mem_busy;
  int           mem_delay;
  logic [3:0]   mem_tag;
  logic [31:0]  mem_addr;
  int           timeouts;

  tb_clock u_clock (.o_clk(clk), .o_reset_n(reset_n));

  ic_top dut (
    .i_clk(clk), .i_reset_n(reset_n), .i_s0_req(s0_req), .o_s0_ready(s0_ready),
    .i_s1_kill(s1_kill), .i_flush(flush), .i_fence_i(fence_i), .o_s2_resp(s2_resp),
    .o_s2_miss(s2_miss), .o_s2_miss_vaddr(s2_miss_vaddr), .o_l2_req(l2_req),
    .i_l2_req_ready(l2_req_ready), .i_l2_resp(l2_resp)
  );

  tb_checker u_checker (
    .i_clk(clk), .i_reset_n(reset_n), .i_s0_req(s0_req), .i_s0_ready(s0_ready),
    .i_s1_kill(s1_kill), .i_flush(flush), .i_fence_i(fence_i), .i_s2_resp(s2_resp),
    .i_s2_miss(s2_miss), .i_s2_miss_vaddr(s2_miss_vaddr), .i_l2_req(l2_req),
    .i_l2_req_ready(l2_req_ready), .i_l2_resp(l2_resp), .o_errors(errors),
    .o_checks(checks), .o_hits(hits), .o_misses(misses), .o_fills(fills)
  );

  function automatic int rnd(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // line pool with three lines in set 3 and two in set 5
  function automatic logic [31:0] pool_addr(input int k);
    case (k)
      0:       return 32'h0000_0030;
      1:       return 32'h0000_0130;
      2:       return 32'h0000_0230;
      3:       return 32'h0000_0150;
      4:       return 32'h0000_0350;
      default: return 32'h0000_0290;
    endcase
  endfunction

  // ========================================
  // memory model called once per clock edge
  // ========================================
  task automatic serve_memory();
    icache_pkg::l2_resp_t r;
    r = '0;
    if (mem_busy) begin
      if (mem_delay == 0) begin
        r.valid  = 1'b1;
        r.tag    = mem_tag;
        r.data   = backing[mem_addr[9:4]];
        mem_busy = 1'b0;
      end else begin
        mem_delay--;
        if (rnd(6) == 0) begin   // stale tag
          r.valid = 1'b1;
          r.tag   = mem_tag ^ 4'h5;
          r.data  = {4{$random(seed)}};
        end
      end
    end else if (l2_req.valid && l2_req_ready) begin
      mem_busy  = 1'b1;
      mem_tag   = l2_req.tag;
      mem_addr  = l2_req.addr;
      mem_delay = rnd(7);
    end
    l2_resp <= r;
  endtask

  task automatic drive_fetch();
    s0_req.valid <= (rnd(10) < 6);
    s0_req.vaddr <= pool_addr(rnd(6)) | 32'(rnd(16));
    flush        <= (rnd(20) == 0);
    fence_i      <= (rnd(60) == 0);
    s1_kill      <= (rnd(12) == 0);
    l2_req_ready <= (rnd(10) < 7);
  endtask

  task automatic quiet_inputs();
    s0_req       <= '0;
    flush        <= 1'b0;
    fence_i      <= 1'b0;
    s1_kill      <= 1'b0;
    l2_req_ready <= 1'b1;
  endtask

  initial begin
    int wait_cnt;
    seed = 32'hbd56_9d1f;
    for (int i = 0; i < 64; i++) begin
      backing[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    s0_req       = '0;
    s1_kill      = 1'b0;
    flush        = 1'b0;
    fence_i      = 1'b0;
    l2_req_ready = 1'b0;
    l2_resp      = '0;
    mem_busy     = 1'b0;
    mem_delay    = 0;
    mem_tag      = 4'd0;
    mem_addr     = 32'd0;
    timeouts     = 0;

    wait_cnt = 0;
    while (reset_n !== 1'b1 && wait_cnt < 10) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (reset_n !== 1'b1) begin
      $display("timeout: reset was never released");
      timeouts++;
    end else begin
      for (int cyc = 0; cyc < 4000; cyc++) begin
        @(posedge clk);
        serve_memory();
        drive_fetch();
      end
      // drain the pipeline and let the last refill finish
      wait_cnt = 0;
      do begin
        @(posedge clk);
        serve_memory();
        quiet_inputs();
        wait_cnt++;
      end while ((wait_cnt < 4 || !s0_ready || mem_busy) && wait_cnt < 300);
      if (!s0_ready || mem_busy) begin
        $display("timeout: refill still outstanding after the stimulus ended");
        timeouts++;
      end
      repeat (4) @(posedge clk);   // pipeline depth
    end

    $display("errors=%0d timeouts=%0d checks=%0d hits=%0d misses=%0d fills=%0d",
             errors, timeouts, checks, hits, misses, fills);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
